/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module cache_tb -o cache_sim \
    && ./obj_dir/cache_sim | tee sim.log \
    || { echo "build or simulation did not run"; exit 1; }
grep -q "^TEST PASS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* src.f */
+incdir+verilog
verilog/cache_pkg.sv
verilog/cache_req_decode.sv
verilog/cache_ctrl.sv
verilog/cache_data_array.sv
verilog/cache_read_mux.sv
verilog/cache_top.sv
testbench/cache_tb_mem.sv
testbench/cache_tb.sv

/* testbench/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();
    localparam int          NUM_TESTS     = 5;
    localparam logic [31:0] SEED          = 32'd28;
    localparam int          OK_TIMEOUT    = 200;
    localparam int          FENCE_TIMEOUT = 3000;

    logic         clk;
    logic         rst;
    cache_req_t   req;
    logic         fence;
    logic         err_en;
    logic         rd_ready;
    logic         rd_last;
    logic         rd_error;
    logic [63:0]  rd_data;
    logic         wr_ready;
    logic         wr_error;
    logic         ok;
    logic         ready;
    logic [63:0]  rdata;
    logic         rw_error;
    logic [31:0]  bus_addr;
    logic         rd_req;
    logic         wr_req;
    logic [511:0] wr_line;

    logic [31:0]  lfsr;
    // expected memory contents by word address
    logic [63:0]  ref_mem [logic [28:0]];
    int           test_errors;
    int           test_num;
    int           pass_count;
    int           fail_count;
    bit           hung;

    cache_top dut (.*);

    cache_tb_mem #(.SEED(SEED)) bus_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [63:0] rand_bits(int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'ha300_0000 : lfsr >> 1;
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] fill_word(logic [28:0] a);
        return {~{a, 3'b000}, {a, 3'b000} ^ 32'h9e37_79b9};
    endfunction

    function automatic logic [63:0] expect_word(logic [28:0] a);
        return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
    endfunction

    function automatic logic [63:0] merge_bytes(logic [63:0] old, logic [63:0] data,
                                                logic [7:0] strb);
        logic [63:0] m;
        m = old;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) m[b*8 +: 8] = data[b*8 +: 8];
        end
        return m;
    endfunction

    // eight tags spread over sets 0 to 3
    function automatic logic [31:0] cached_addr();
        logic [2:0] tag;
        logic [1:0] set;
        logic [2:0] off;
        tag = 3'(rand_bits(3));
        set = 2'(rand_bits(2));
        off = 3'(rand_bits(3));
        return {1'b1, 17'd0, tag, 3'd0, set, off, 3'b000};
    endfunction

    task automatic check(string what, logic [63:0] got, logic [63:0] exp);
        if (!hung && got !== exp) begin
            $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
            test_errors++;
        end
    endtask

    task automatic wait_ok(string what);
        int n;
        n = 0;
        #1;
        while (!ok && !hung) begin
            if (n == OK_TIMEOUT) begin
                $display("timed out waiting for ok on a %s", what);
                hung = 1'b1;
            end else begin
                @(negedge clk);
                #1;
                n++;
            end
        end
        // the edge that completes the request
        @(negedge clk);
    endtask

    task automatic access(cache_op_e op, logic [31:0] addr, logic [7:0] strb,
                          logic [63:0] data, output logic [63:0] rd, output logic err);
        req = '{valid: 1'b1, op: op, addr: addr, wstrb: strb, wdata: data};
        wait_ok("core request");
        rd = rdata;
        err = rw_error;
        req = '0;
        @(negedge clk);
    endtask

    task automatic random_traffic();
        logic [31:0] a;
        logic [63:0] d;
        logic [63:0] rd;
        logic        err;
        for (int i = 0; i < 300; i++) begin
            a = cached_addr();
            d = rand_bits(64);
            if (rand_bits(1) != '0) begin
                access(op_write, a, 8'hff, d, rd, err);
                ref_mem[a[31:3]] = d;
            end else begin
                access(op_read, a, 8'h00, '0, rd, err);
                check("cached load", rd, expect_word(a[31:3]));
            end
        end
    endtask

    task automatic partial_stores();
        logic [31:0] a;
        logic [63:0] d;
        logic [7:0]  s;
        logic [63:0] rd;
        logic        err;
        for (int i = 0; i < 60; i++) begin
            a = cached_addr();
            d = rand_bits(64);
            s = 8'(rand_bits(8));
            if (s == 8'h00) s = 8'h01;
            access(op_write, a, s, d, rd, err);
            ref_mem[a[31:3]] = merge_bytes(expect_word(a[31:3]), d, s);
            access(op_read, a, 8'h00, '0, rd, err);
            check("partial store", rd, expect_word(a[31:3]));
        end
    endtask

    task automatic uncached_traffic();
        logic [31:0] a;
        logic [63:0] d;
        logic [63:0] rd;
        logic        err;
        for (int i = 0; i < 8; i++) begin
            a = {21'd0, 8'(rand_bits(8)), 3'b000};
            d = rand_bits(64);
            access(op_write, a, 8'hff, d, rd, err);
            check("uncached store in memory", bus_mem.words[a[31:3]], d);
            ref_mem[a[31:3]] = d;
            access(op_read, a, 8'h00, '0, rd, err);
            check("uncached load", rd, bus_mem.words[a[31:3]]);
        end
    endtask

    task automatic fence_flush();
        logic [31:0] a;
        logic [63:0] d;
        logic [63:0] rd;
        logic        err;
        int          n;
        for (int i = 0; i < 40; i++) begin
            a = cached_addr();
            d = rand_bits(64);
            access(op_write, a, 8'hff, d, rd, err);
            ref_mem[a[31:3]] = d;
        end
        fence = 1'b1;
        @(negedge clk);
        fence = 1'b0;
        n = 0;
        while (ready && !hung) begin
            if (n == OK_TIMEOUT) begin
                $display("ready never fell after the fence pulse");
                hung = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
        n = 0;
        while (!ready && !hung) begin
            if (n == FENCE_TIMEOUT) begin
                $display("timed out waiting for the fence walk to finish");
                hung = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
        foreach (ref_mem[k]) begin
            check("memory after fence", bus_mem.words[k], ref_mem[k]);
        end
    endtask

    // both ops with and without an injected bus error
    task automatic injected_bus_errors();
        logic [31:0] a;
        logic [63:0] d;
        logic [63:0] rd;
        logic        err;
        cache_op_e   op;
        for (int i = 0; i < 8; i++) begin
            a = {21'd0, 8'(rand_bits(8)), 3'b000};
            d = rand_bits(64);
            op = i[1] ? op_write : op_read;
            err_en = i[0];
            access(op, a, 8'hff, d, rd, err);
            err_en = 1'b0;
            check("bus error flag", 64'(err), 64'(i[0]));
            if (op == op_write && !i[0]) ref_mem[a[31:3]] = d;
            if (op == op_read && !i[0]) check("uncached load", rd, expect_word(a[31:3]));
        end
    endtask

    task automatic finish_test(string name);
        test_num++;
        if (test_errors == 0 && !hung) begin
            pass_count++;
            $display("test %0d %s: passed", test_num, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed, %0d mismatches", test_num, name, test_errors);
        end
        test_errors = 0;
    endtask

    initial begin
        lfsr        = SEED;
        rst         = 1'b1;
        req         = '0;
        fence       = 1'b0;
        err_en      = 1'b0;
        hung        = 1'b0;
        test_errors = 0;
        test_num    = 0;
        pass_count  = 0;
        fail_count  = 0;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        random_traffic();
        finish_test("random cached access");
        partial_stores();
        finish_test("partial stores");
        uncached_traffic();
        finish_test("uncached access");
        fence_flush();
        finish_test("fence writeback");
        injected_bus_errors();
        finish_test("uncached bus error");
        $display("closing count: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == NUM_TESTS) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* testbench/cache_tb_mem.sv */
`timescale 1ns/1ps

module cache_tb_mem #(
    parameter logic [31:0] SEED = 32'd28
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         err_en,
    input  logic [31:0]  bus_addr,
    input  logic         rd_req,
    input  logic         wr_req,
    input  logic [511:0] wr_line,
    output logic         rd_ready,
    output logic         rd_last,
    output logic [63:0]  rd_data,
    output logic         rd_error,
    output logic         wr_ready,
    output logic         wr_error
);
    // keyed by word address
    logic [63:0] words [logic [28:0]];
    logic [31:0] lfsr;
    logic [2:0]  beat;

    function automatic logic [63:0] fill_word(logic [28:0] a);
        return {~{a, 3'b000}, {a, 3'b000} ^ 32'h9e37_79b9};
    endfunction

    // untouched words come up with the fill pattern
    function automatic logic [63:0] word_at(logic [28:0] a);
        if (!words.exists(a)) words[a] = fill_word(a);
        return words[a];
    endfunction

    function automatic logic next_bit();
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'ha300_0000 : lfsr >> 1;
        return lfsr[0];
    endfunction

    initial begin
        lfsr     = SEED;
        beat     = 3'd0;
        rd_ready = 1'b0;
        rd_last  = 1'b0;
        rd_data  = 64'd0;
        rd_error = 1'b0;
        wr_ready = 1'b0;
        wr_error = 1'b0;
    end

    // ready decided one half cycle before the edge that moves the beat
    always @(negedge clk) begin
        rd_ready = 1'b0;
        rd_last  = 1'b0;
        rd_error = 1'b0;
        wr_ready = 1'b0;
        wr_error = 1'b0;
        if (rst) begin
            beat = 3'd0;
        end else if (rd_req && next_bit()) begin
            rd_ready = 1'b1;
            rd_data  = word_at(bus_addr[31:3] + 29'(beat));
            rd_last  = !bus_addr[31] || &beat;
            rd_error = !bus_addr[31] && err_en;
            beat     = rd_last ? 3'd0 : beat + 3'd1;
        end else if (wr_req && next_bit()) begin
            wr_ready = 1'b1;
            wr_error = !bus_addr[31] && err_en;
            if (bus_addr[31]) begin
                for (int i = 0; i < 8; i++) begin
                    words[bus_addr[31:3] + 29'(i)] = wr_line[i*64 +: 64];
                end
            end else if (!err_en) begin
                words[bus_addr[31:3]] = wr_line[63:0];
            end
        end
    end

endmodule

/* verilog/cache_ctrl.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_ctrl import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  cache_req_t                  req,
    input  cache_access_t               acc,
    input  logic                        fence,
    input  logic                        rd_ready,
    input  logic                        rd_last,
    input  logic                        rd_error,
    input  logic                        wr_ready,
    input  logic                        wr_error,
    output logic                        ok,
    output logic                        ready,
    output logic [31:0]                 bus_addr,
    output logic                        rd_req,
    output logic                        wr_req,
    output logic [`CACHE_INDEX_W:0]     arr_index,
    output logic                        arr_wen,
    output logic [`CACHE_OFFSET_W-1:0]  arr_refill_beat,
    output logic                        arr_refill,
    output logic                        uncache_done,
    output logic                        bus_error
);
    localparam int LINES   = `CACHE_SETS * `CACHE_WAYS;
    localparam int LINE_AW = `CACHE_INDEX_W + 1;
    localparam int BYTE_W  = `CACHE_OFFSET_W + 3;

    logic [`CACHE_TAG_W-1:0]    tag_mem [LINES];
    logic [LINES-1:0]           valid_bits;
    logic [LINES-1:0]           dirty_bits;
    // way touched last in each set
    logic [`CACHE_SETS-1:0]     mru;

    cache_state_e               state;
    logic [LINE_AW-1:0]         count;
    logic [`CACHE_OFFSET_W-1:0] beat;
    logic                       fence_pend;
    cache_req_t                 done_req;

    logic [LINE_AW-1:0]         line0;
    logic [LINE_AW-1:0]         line1;
    logic [LINE_AW-1:0]         victim_line;
    logic                       hit0, hit1, hit, miss;
    logic                       victim, victim_dirty;
    logic                       rd_fire, wr_fire, done_match;
    logic                       fence_go, fence_dirty, fence_step;

    assign line0 = {acc.index, 1'b0};
    assign line1 = {acc.index, 1'b1};
    assign hit0  = valid_bits[line0] && tag_mem[line0] == acc.tag;
    assign hit1  = valid_bits[line1] && tag_mem[line1] == acc.tag;
    assign hit   = req.valid && !acc.uncache && (hit0 || hit1) && state == st_idle;
    assign miss  = req.valid && !acc.uncache && !(hit0 || hit1) && state == st_idle;

    // empty way first, then the clean one, then the older one
    always_comb begin
        if (!valid_bits[line0] || !valid_bits[line1]) begin
            victim = valid_bits[line0];
        end else if (dirty_bits[line0] != dirty_bits[line1]) begin
            victim = dirty_bits[line0];
        end else begin
            victim = !mru[acc.index];
        end
    end

    assign victim_line  = {acc.index, victim};
    assign victim_dirty = valid_bits[victim_line] && dirty_bits[victim_line];

    assign rd_fire     = rd_req && rd_ready;
    assign wr_fire     = wr_req && wr_ready;
    assign done_match  = uncache_done && req == done_req;
    assign fence_go    = (fence || fence_pend) && state == st_idle;
    assign fence_dirty = valid_bits[count] && dirty_bits[count];
    assign fence_step  = state == st_fence && (!fence_dirty || wr_fire);

    assign ok      = acc.uncache ? done_match : hit;
    assign ready   = state != st_fence;
    assign rd_req  = state == st_refill;
    assign wr_req  = state == st_writeback || (state == st_fence && fence_dirty);

    always_comb begin
        case (state)
            st_fence:
                bus_addr = {tag_mem[count], count[LINE_AW-1:1], {BYTE_W{1'b0}}};
            st_writeback:
                bus_addr = acc.uncache ? {req.addr[31:3], 3'b000}
                                       : {tag_mem[victim_line], acc.index, {BYTE_W{1'b0}}};
            default:
                bus_addr = acc.uncache ? {req.addr[31:3], 3'b000}
                                       : {acc.tag, acc.index, {BYTE_W{1'b0}}};
        endcase
    end

    assign arr_index       = state == st_fence ? count : {acc.index, hit ? hit1 : victim};
    assign arr_refill      = rd_fire && !acc.uncache;
    assign arr_wen         = arr_refill || (hit && req.op == op_write);
    assign arr_refill_beat = beat;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (fence_go) begin
                        state <= st_fence;
                    end else if (acc.uncache && !done_match) begin
                        state <= req.op == op_write ? st_writeback : st_refill;
                    end else if (miss) begin
                        state <= victim_dirty ? st_writeback : st_refill;
                    end
                end
                st_refill: begin
                    if (rd_fire && rd_last) state <= st_idle;
                end
                st_writeback: begin
                    if (wr_fire) state <= acc.uncache ? st_idle : st_refill;
                end
                st_fence: begin
                    if (fence_step && &count) state <= st_idle;
                end
            endcase
        end
    end

    // fence seen during a miss waits for idle
    always_ff @(posedge clk) begin
        if (rst || state == st_idle) begin
            fence_pend <= 1'b0;
        end else if (fence) begin
            fence_pend <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != st_fence) begin
            count <= '0;
        end else if (fence_step) begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat <= '0;
        end else if (arr_refill) begin
            beat <= rd_last ? '0 : beat + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uncache_done <= 1'b0;
            bus_error    <= 1'b0;
        end else if (acc.uncache && (rd_fire || wr_fire)) begin
            uncache_done <= 1'b1;
            bus_error    <= rd_fire ? rd_error : wr_error;
        end else begin
            // held until the core withdraws or changes the request
            if (!done_match) uncache_done <= 1'b0;
            if (hit) bus_error <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (acc.uncache && (rd_fire || wr_fire)) done_req <= req;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            mru        <= '0;
        end else if (hit) begin
            mru[acc.index] <= hit1;
            if (req.op == op_write) dirty_bits[hit1 ? line1 : line0] <= 1'b1;
        end else if (arr_refill && rd_last) begin
            valid_bits[victim_line] <= 1'b1;
            dirty_bits[victim_line] <= 1'b0;
        end else if (wr_fire) begin
            if (state == st_fence) begin
                dirty_bits[count] <= 1'b0;
            end else if (!acc.uncache) begin
                dirty_bits[victim_line] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr_refill && rd_last) tag_mem[victim_line] <= acc.tag;
    end

    // the bus answers only reads that control asked for
    a_beat_in_refill: assert property (@(posedge clk) disable iff (rst)
        rd_ready |-> state == st_refill);

    // last refill beat must be the eighth
    a_refill_len: assert property (@(posedge clk) disable iff (rst)
        arr_refill && rd_last |-> &beat);

    // a finished walk leaves no dirty line behind
    a_fence_clean: assert property (@(posedge clk) disable iff (rst)
        fence_step && &count |=> dirty_bits == '0);

endmodule

/* verilog/cache_data_array.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_data_array import cache_pkg::*; (
    input  logic                        clk,
    input  logic [`CACHE_INDEX_W:0]     arr_index,
    input  logic                        arr_wen,
    input  logic                        arr_refill,
    input  logic [`CACHE_OFFSET_W-1:0]  arr_refill_beat,
    input  cache_access_t               acc,
    input  logic [7:0]                  wstrb,
    input  logic [63:0]                 wdata,
    input  logic [63:0]                 rd_data,
    output logic [`CACHE_LINE_W-1:0]    line_q
);
    localparam int LINES = `CACHE_SETS * `CACHE_WAYS;

    logic [`CACHE_LINE_WORDS-1:0][63:0] mem [LINES];
    logic [`CACHE_OFFSET_W-1:0]         word_sel;
    logic [63:0]                        word_old;
    logic [63:0]                        word_new;

    // refill beats fill the line in order, stores hit one word
    assign word_sel = arr_refill ? arr_refill_beat : acc.offset;
    assign word_old = mem[arr_index][word_sel];

    always_comb begin
        for (int b = 0; b < 8; b++) begin
            if (arr_refill) begin
                word_new[b*8 +: 8] = rd_data[b*8 +: 8];
            end else if (wstrb[b]) begin
                word_new[b*8 +: 8] = wdata[b*8 +: 8];
            end else begin
                word_new[b*8 +: 8] = word_old[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr_wen) mem[arr_index][word_sel] <= word_new;
    end

    assign line_q = mem[arr_index];

endmodule

/* verilog/cache_pkg.sv */
`include "cache_settings.svh"

package cache_pkg;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } cache_op_e;

    typedef struct packed {
        logic        valid;
        cache_op_e   op;
        logic [31:0] addr;
        logic [7:0]  wstrb;
        logic [63:0] wdata;
    } cache_req_t;

    typedef struct packed {
        logic [`CACHE_TAG_W-1:0]    tag;
        logic [`CACHE_INDEX_W-1:0]  index;
        logic [`CACHE_OFFSET_W-1:0] offset;
        logic                       uncache;
    } cache_access_t;

    typedef enum logic [1:0] {
        st_idle      = 2'b00,
        st_fence     = 2'b01,
        st_refill    = 2'b10,
        st_writeback = 2'b11
    } cache_state_e;

endpackage

/* verilog/cache_read_mux.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_read_mux import cache_pkg::*; (
    input  logic                        clk,
    input  cache_access_t               acc,
    input  logic [`CACHE_LINE_W-1:0]    line_q,
    input  logic [63:0]                 rd_data,
    input  logic                        rd_fire,
    input  logic                        bus_error,
    output logic [63:0]                 rdata,
    output logic                        rw_error
);
    logic [`CACHE_LINE_WORDS-1:0][63:0] line_words;
    logic                               uncache_q;
    logic [63:0]                        line_word_q;
    logic [63:0]                        bus_word_q;

    assign line_words = line_q;

    // line_q follows the next request, so keep the word now
    always_ff @(posedge clk) begin
        uncache_q   <= acc.uncache;
        line_word_q <= line_words[acc.offset];
        rw_error    <= bus_error;
        if (acc.uncache && rd_fire) bus_word_q <= rd_data;
    end

    assign rdata = uncache_q ? bus_word_q : line_word_q;

endmodule

/* verilog/cache_req_decode.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_req_decode import cache_pkg::*; (
    input  cache_req_t    req,
    output cache_access_t acc
);
    // bits 2:0 select the byte inside a word
    localparam int OFF_LSB = 3;
    localparam int IDX_LSB = OFF_LSB + `CACHE_OFFSET_W;

    always_comb begin
        acc.tag    = req.addr[31 -: `CACHE_TAG_W];
        acc.index  = req.addr[IDX_LSB +: `CACHE_INDEX_W];
        acc.offset = req.addr[OFF_LSB +: `CACHE_OFFSET_W];
        // low half of the address space bypasses the arrays
        acc.uncache = req.valid && !req.addr[31];
    end

    // a store must touch at least one byte
    always_comb begin
        if (req.valid && req.op == op_write) begin
            assert (req.wstrb != 8'h00)
            else $error("store request with empty byte strobe");
        end
    end

endmodule

/* verilog/cache_settings.svh */
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// address fields from tag down to byte
`define CACHE_TAG_W      21
`define CACHE_INDEX_W    5
`define CACHE_OFFSET_W   3

`define CACHE_SETS       32
`define CACHE_WAYS       2
`define CACHE_LINE_WORDS 8
`define CACHE_LINE_W     512

`endif

/* verilog/cache_top.sv */
`timescale 1ns/1ps
`include "cache_settings.svh"

module cache_top import cache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  cache_req_t                  req,
    input  logic                        fence,
    input  logic                        rd_ready,
    input  logic                        rd_last,
    input  logic                        rd_error,
    input  logic [63:0]                 rd_data,
    input  logic                        wr_ready,
    input  logic                        wr_error,
    output logic                        ok,
    output logic                        ready,
    output logic [63:0]                 rdata,
    output logic                        rw_error,
    output logic [31:0]                 bus_addr,
    output logic                        rd_req,
    output logic                        wr_req,
    output logic [`CACHE_LINE_W-1:0]    wr_line
);
    cache_access_t                      acc;
    logic [`CACHE_INDEX_W:0]            arr_index;
    logic                               arr_wen;
    logic                               arr_refill;
    logic [`CACHE_OFFSET_W-1:0]         arr_refill_beat;
    logic                               uncache_done;
    logic                               bus_error;
    logic                               rd_fire;
    logic [`CACHE_LINE_W-1:0]           line_q;

    assign rd_fire = rd_req && rd_ready && !uncache_done;

    // uncached store data rides in the low word
    assign wr_line = acc.uncache ? {line_q[`CACHE_LINE_W-1:64], req.wdata} : line_q;

    cache_req_decode u_decode (.req(req), .acc(acc));

    cache_ctrl u_ctrl (
        .clk(clk), .rst(rst), .req(req), .acc(acc), .fence(fence),
        .rd_ready(rd_ready), .rd_last(rd_last), .rd_error(rd_error),
        .wr_ready(wr_ready), .wr_error(wr_error), .ok(ok), .ready(ready),
        .bus_addr(bus_addr), .rd_req(rd_req), .wr_req(wr_req),
        .arr_index(arr_index), .arr_wen(arr_wen), .arr_refill_beat(arr_refill_beat),
        .arr_refill(arr_refill), .uncache_done(uncache_done), .bus_error(bus_error)
    );

    cache_data_array u_array (
        .clk(clk), .arr_index(arr_index), .arr_wen(arr_wen), .arr_refill(arr_refill),
        .arr_refill_beat(arr_refill_beat), .acc(acc), .wstrb(req.wstrb),
        .wdata(req.wdata), .rd_data(rd_data), .line_q(line_q)
    );

    cache_read_mux u_result (
        .clk(clk), .acc(acc), .line_q(line_q), .rd_data(rd_data), .rd_fire(rd_fire),
        .bus_error(bus_error), .rdata(rdata), .rw_error(rw_error)
    );

endmodule
